/* compile.f */
design/vshift_pkg.sv
design/simd_left_shift.sv
design/shift_operand_prep.sv
design/shift_result_merge.sv
design/beat_counter.sv
design/shift_ctrl_fsm.sv
design/vshift_top.sv
verif/vshift_assert.sv
verif/tb_vshift.sv

/* verif/tb_vshift.sv */
`timescale 1ns/10ps

module tb_vshift import vshift_pkg::*; ();

  localparam int cmd_count   = 300;
  localparam int cycle_limit = 40 * cmd_count + 10;

  logic         forever_cpuclk;
  logic         reset;
  logic         cmd_start;
  vshift_cmd_t  cmd;
  logic         src_valid;
  vshift_beat_t src_beat;
  logic         busy;
  logic         res_valid;
  vshift_res_t  res;
  logic         done;

  logic [31:0]  lfsr;
  vshift_res_t  exp_q[$];
  logic         exp_busy;
  logic         exp_valid;
  logic         exp_done;
  int           err_res;
  int           err_ctl;
  int           err_sva;
  int           cycle_cnt;

  vshift_top UUT (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .cmd_start      (cmd_start),
    .cmd            (cmd),
    .src_valid      (src_valid),
    .src_beat       (src_beat),
    .busy           (busy),
    .res_valid      (res_valid),
    .res            (res),
    .done           (done)
  );

  initial
  begin
    forever_cpuclk = 1'b0;
    forever #4 forever_cpuclk = ~forever_cpuclk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r[i] = lfsr[0];
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // Reference model shifts each element by its own amount modulo the width
  function automatic logic [63:0] model_shift(input shift_op_e op, input elem_size_e size,
                                              input logic [63:0] src, input logic [63:0] amt);
    int          w;
    int          c;
    logic [63:0] mask;
    logic [63:0] v;
    logic [63:0] r;
    w    = (size == e16) ? 16 : (size == e32) ? 32 : 64;
    mask = (w == 64) ? {64{1'b1}} : ((64'd1 << w) - 64'd1);
    r    = '0;
    for (int e = 0; e < 64 / w; e++)
    begin
      v = (src >> (w * e)) & mask;
      c = (amt >> (w * e)) & (w - 1);
      case (op)
        op_sll: v = v << c;
        op_srl: v = v >> c;
        default:
        begin
          if (v[w-1])
            v = v | ~mask;
          v = $signed(v) >>> c;
        end
      endcase
      r = r | ((v & mask) << (w * e));
    end
    return r;
  endfunction

  task automatic check_res(input vshift_res_t act, input vshift_res_t exp);
    if (act !== exp)
    begin
      $display("Error: res act=%h exp=%h (data %h/%h idx %h/%h) at %0t",
               act, exp, act.data, exp.data, act.idx, exp.idx, $time);
      err_res++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("Error: %s act=%h exp=%h at %0t", name, act, exp, $time);
      err_ctl++;
    end
  endtask

  // Advance one clock and compare the registered outputs
  task automatic tick();
    vshift_res_t want;
    @(posedge forever_cpuclk);
    #1;
    check_bit("busy", busy, exp_busy);
    check_bit("done", done, exp_done);
    check_bit("res_valid", res_valid, exp_valid);
    if (res_valid === 1'b1)
    begin
      if (exp_q.size() == 0)
      begin
        $display("A result appeared with no accepted beat before it at %0t", $time);
        err_ctl++;
      end
      else
      begin
        want = exp_q.pop_front();
        check_res(res, want);
      end
    end
  endtask

  task automatic run_command();
    vshift_cmd_t  c;
    vshift_beat_t b;
    vshift_res_t  r;
    int           gap;
    case (int'(rand_bits(2)) % 3)
      0:       c.op = op_sll;
      1:       c.op = op_srl;
      default: c.op = op_sra;
    endcase
    case (int'(rand_bits(2)) % 3)
      0:       c.size = e16;
      1:       c.size = e32;
      default: c.size = e64;
    endcase
    c.last_beat_idx = beat_idx_w'(rand_bits(2));
    cmd_start = 1'b1;
    cmd       = c;
    // Stray strobe while idle
    src_valid = 1'(rand_bits(1));
    src_beat  = {rand_bits(64), rand_bits(64)};
    exp_busy  = 1'b1;
    exp_valid = 1'b0;
    exp_done  = 1'b0;
    tick();
    cmd_start = 1'b0;
    for (int i = 0; i <= c.last_beat_idx; i++)
    begin
      gap = rand_bits(1) ? 0 : int'(rand_bits(2));
      repeat (gap)
      begin
        src_valid = 1'b0;
        // Second command while busy
        cmd_start = 1'(rand_bits(1));
        cmd       = vshift_cmd_t'(7'(rand_bits(7)));
        exp_valid = 1'b0;
        exp_done  = 1'b0;
        tick();
      end
      cmd_start = 1'b0;
      b.src = rand_bits(64);
      // Mix of all-zero, all-max and random counts
      case (rand_bits(2))
        0:       b.amt = '0;
        1:       b.amt = '1;
        default: b.amt = rand_bits(64);
      endcase
      src_valid = 1'b1;
      src_beat  = b;
      r.data    = model_shift(c.op, c.size, b.src, b.amt);
      r.idx     = beat_idx_w'(i);
      exp_q.push_back(r);
      exp_valid = 1'b1;
      exp_done  = (i == c.last_beat_idx);
      tick();
    end
    // Strobes in the drain cycle are dropped
    src_valid = 1'(rand_bits(1));
    cmd_start = 1'(rand_bits(1));
    exp_busy  = 1'b0;
    exp_valid = 1'b0;
    exp_done  = 1'b0;
    tick();
    src_valid = 1'b0;
    cmd_start = 1'b0;
  endtask

  initial
  begin
    cycle_cnt = 0;
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge forever_cpuclk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    lfsr      = 32'hfea6_6386;
    err_res   = 0;
    err_ctl   = 0;
    err_sva   = 0;
    reset     = 1'b1;
    cmd_start = 1'b0;
    cmd       = '0;
    src_valid = 1'b0;
    src_beat  = '0;
    exp_busy  = 1'b0;
    exp_valid = 1'b0;
    exp_done  = 1'b0;
    repeat (10) @(posedge forever_cpuclk);
    #1;
    reset = 1'b0;
    // Outputs stay low before the first command
    repeat (3)
    begin
      src_valid = 1'(rand_bits(1));
      src_beat  = {rand_bits(64), rand_bits(64)};
      tick();
    end
    src_valid = 1'b0;
    repeat (cmd_count) run_command();
    if (exp_q.size() != 0)
    begin
      $display("%0d expected results never appeared", exp_q.size());
      err_ctl++;
    end
    err_sva = UUT.u_assert.fail_cnt;
    $display("Errors: result %0d, control %0d, assertion %0d", err_res, err_ctl, err_sva);
    if (err_res == 0 && err_ctl == 0 && err_sva == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* verif/vshift_assert.sv */
`timescale 1ns/10ps

module vshift_assert (
  input logic forever_cpuclk,
  input logic reset,
  input logic busy,
  input logic done,
  input logic res_valid,
  input logic beat_accept
);

  // Number of assertion failures so far
  int fail_cnt = 0;

  // Last result and done share a cycle
  a_done_with_valid: assert property (@(posedge forever_cpuclk) disable iff (reset)
    done |-> res_valid)
  else
  begin
    $error("done raised without res_valid");
    fail_cnt++;
  end

  // Every result comes from a beat taken one cycle before
  a_valid_after_accept: assert property (@(posedge forever_cpuclk) disable iff (reset)
    res_valid |-> $past(beat_accept))
  else
  begin
    $error("res_valid without an accepted beat one cycle earlier");
    fail_cnt++;
  end

  // Command ends only through the done cycle
  a_busy_falls_after_done: assert property (@(posedge forever_cpuclk) disable iff (reset)
    $fell(busy) |-> $past(done))
  else
  begin
    $error("busy fell without done");
    fail_cnt++;
  end

  // Outputs held quiet by reset
  a_quiet_in_reset: assert property (@(posedge forever_cpuclk)
    reset |=> (!busy && !done && !res_valid))
  else
  begin
    $error("control output high during reset");
    fail_cnt++;
  end

endmodule

bind vshift_top vshift_assert u_assert (
  .forever_cpuclk (forever_cpuclk),
  .reset          (reset),
  .busy           (busy),
  .done           (done),
  .res_valid      (res_valid),
  .beat_accept    (beat_accept)
);

/* design/vshift_top.sv */
`timescale 1ns/10ps

module vshift_top import vshift_pkg::*; (
  input  logic         forever_cpuclk,
  input  logic         reset,
  input  logic         cmd_start,
  input  vshift_cmd_t  cmd,
  input  logic         src_valid,
  input  vshift_beat_t src_beat,
  output logic         busy,
  output logic         res_valid,
  output vshift_res_t  res,
  output logic         done
);

  vshift_cmd_t           cmd_q;
  logic                  beat_accept;
  logic                  cmd_latch;
  logic                  last_beat;
  logic [beat_idx_w-1:0] beat_idx;
  lane_cnt_t             cnt;
  logic [data_w-1:0]     shift_src;
  logic [data_w-1:0]     l16_out;
  logic [data_w-1:0]     l32_out;
  logic [data_w-1:0]     l64_out;

  shift_ctrl_fsm u_ctrl (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .cmd_start      (cmd_start),
    .cmd            (cmd),
    .src_valid      (src_valid),
    .last_beat      (last_beat),
    .cmd_q          (cmd_q),
    .beat_accept    (beat_accept),
    .cmd_latch      (cmd_latch),
    .busy           (busy),
    .done           (done)
  );

  beat_counter u_cnt (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .clear          (cmd_latch),
    .beat_accept    (beat_accept),
    .last_beat_idx  (cmd_q.last_beat_idx),
    .beat_idx       (beat_idx),
    .last_beat      (last_beat)
  );

  shift_operand_prep u_prep (
    .cmd_q     (cmd_q),
    .beat      (src_beat),
    .cnt       (cnt),
    .shift_src (shift_src)
  );

  simd_left_shift u_shift (
    .in_size (cmd_q.size),
    .cnt     (cnt),
    .src     (shift_src),
    .l16_out (l16_out),
    .l32_out (l32_out),
    .l64_out (l64_out)
  );

  shift_result_merge u_merge (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset),
    .beat_accept    (beat_accept),
    .cmd_q          (cmd_q),
    .beat_idx       (beat_idx),
    .orig_src       (src_beat.src),
    .cnt            (cnt),
    .l16_out        (l16_out),
    .l32_out        (l32_out),
    .l64_out        (l64_out),
    .res_valid      (res_valid),
    .res            (res)
  );

endmodule

/* design/shift_ctrl_fsm.sv */
`timescale 1ns/10ps

module shift_ctrl_fsm import vshift_pkg::*; (
  input  logic        forever_cpuclk,
  input  logic        reset,
  input  logic        cmd_start,
  input  vshift_cmd_t cmd,
  input  logic        src_valid,
  input  logic        last_beat,
  output vshift_cmd_t cmd_q,
  output logic        beat_accept,
  output logic        cmd_latch,
  output logic        busy,
  output logic        done
);

  typedef enum logic [1:0] {
    idle  = 2'd0,
    run   = 2'd1,
    drain = 2'd2
  } state_e;

  state_e state;
  state_e state_next;

  // New commands only from idle
  assign cmd_latch   = cmd_start && (state == idle);
  // Source strobes count only while running
  assign beat_accept = src_valid && (state == run);
  assign busy        = (state != idle);
  // Drain lines up with the last result beat
  assign done        = (state == drain);

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
        if (cmd_start)
          state_next = run;
      run:
        if (beat_accept && last_beat)
          state_next = drain;
      default:
        state_next = idle;
    endcase
  end

  always_ff @(posedge forever_cpuclk)
  begin
    if (reset)
      state <= idle;
    else
      state <= state_next;
  end

  always_ff @(posedge forever_cpuclk)
  begin
    if (reset)
      cmd_q <= '{op: op_sll, size: e64, last_beat_idx: '0};
    else if (cmd_latch)
      cmd_q <= cmd;
  end

endmodule

/* design/beat_counter.sv */
`timescale 1ns/10ps

module beat_counter import vshift_pkg::*; (
  input  logic                  forever_cpuclk,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  beat_accept,
  input  logic [beat_idx_w-1:0] last_beat_idx,
  output logic [beat_idx_w-1:0] beat_idx,
  output logic                  last_beat
);

  // Index of the next beat to accept
  always_ff @(posedge forever_cpuclk)
  begin
    if (reset)
      beat_idx <= '0;
    else if (clear)
      beat_idx <= '0;
    else if (beat_accept)
      beat_idx <= beat_idx + 1'b1;
  end

  // Next accepted beat closes the command
  assign last_beat = (beat_idx == last_beat_idx);

endmodule

/* design/shift_result_merge.sv */
`timescale 1ns/10ps

module shift_result_merge import vshift_pkg::*; (
  input  logic                  forever_cpuclk,
  input  logic                  reset,
  input  logic                  beat_accept,
  input  vshift_cmd_t           cmd_q,
  input  logic [beat_idx_w-1:0] beat_idx,
  input  logic [data_w-1:0]     orig_src,
  input  lane_cnt_t             cnt,
  input  logic [data_w-1:0]     l16_out,
  input  logic [data_w-1:0]     l32_out,
  input  logic [data_w-1:0]     l64_out,
  output logic                  res_valid,
  output vshift_res_t           res
);

  logic              right_shift;
  logic [data_w-1:0] lane_sel;
  logic [data_w-1:0] unrev;
  logic [data_w-1:0] sign_fill;
  logic [data_w-1:0] merged;

  assign right_shift = (cmd_q.op != op_sll);

  always_comb
  begin
    case (cmd_q.size)
      e16:     lane_sel = l16_out;
      e32:     lane_sel = l32_out;
      default: lane_sel = l64_out;
    endcase
  end

  // Undo the input reversal
  always_comb
  begin
    for (int b = 0; b < data_w; b++)
      unrev[b] = lane_sel[data_w-1-b];
  end

  // Sign fill over the top count bits of negative elements
  // Counts are lane-mirrored here, element e reads lane 3-e or 1-e
  always_comb
  begin
    sign_fill = '0;
    case (cmd_q.size)
      e16:
        for (int e = 0; e < 4; e++)
          if (orig_src[16*e+15])
            sign_fill[16*e +: 16] = ~(16'hffff >> cnt.c16[3-e]);
      e32:
        for (int e = 0; e < 2; e++)
          if (orig_src[32*e+31])
            sign_fill[32*e +: 32] = ~(32'hffff_ffff >> cnt.c32[1-e]);
      default:
        if (orig_src[63])
          sign_fill = ~({data_w{1'b1}} >> cnt.c64);
    endcase
  end

  always_comb
  begin
    if (cmd_q.op == op_sra)
      merged = unrev | sign_fill;
    else if (right_shift)
      merged = unrev;
    else
      merged = lane_sel;
  end

  always_ff @(posedge forever_cpuclk)
  begin
    if (reset)
      res_valid <= 1'b0;
    else
      res_valid <= beat_accept;
  end

  always_ff @(posedge forever_cpuclk)
  begin
    if (beat_accept)
    begin
      res.data <= merged;
      res.idx  <= beat_idx;
    end
  end

endmodule

/* design/shift_operand_prep.sv */
`timescale 1ns/10ps

module shift_operand_prep import vshift_pkg::*; (
  input  vshift_cmd_t       cmd_q,
  input  vshift_beat_t      beat,
  output lane_cnt_t         cnt,
  output logic [data_w-1:0] shift_src
);

  logic      right_shift;
  lane_cnt_t amt_cnt;

  assign right_shift = (cmd_q.op == op_srl) || (cmd_q.op == op_sra);

  // Low bits of each amount element, only the active size is populated
  always_comb
  begin
    amt_cnt = '0;
    case (cmd_q.size)
      e16:
        for (int k = 0; k < 4; k++)
          amt_cnt.c16[k] = beat.amt[16*k +: 4];
      e32:
        for (int j = 0; j < 2; j++)
          amt_cnt.c32[j] = beat.amt[32*j +: 5];
      default:
        amt_cnt.c64 = beat.amt[5:0];
    endcase
  end

  // Right shifts run through the left shifter on a reversed word
  always_comb
  begin
    cnt       = amt_cnt;
    shift_src = beat.src;
    if (right_shift)
    begin
      // Element e now sits in lane 3-e (or 1-e for 32 bits)
      for (int k = 0; k < 4; k++)
        cnt.c16[k] = amt_cnt.c16[3-k];
      for (int j = 0; j < 2; j++)
        cnt.c32[j] = amt_cnt.c32[1-j];
      for (int b = 0; b < data_w; b++)
        shift_src[b] = beat.src[data_w-1-b];
    end
  end

endmodule

/* design/simd_left_shift.sv */
`timescale 1ns/10ps

module simd_left_shift import vshift_pkg::*; (
  input  elem_size_e        in_size,
  input  lane_cnt_t         cnt,
  input  logic [data_w-1:0] src,
  output logic [data_w-1:0] l16_out,
  output logic [data_w-1:0] l32_out,
  output logic [data_w-1:0] l64_out
);

  logic             size_16;
  logic             size_32;
  logic             size_64;
  logic [3:0][3:0]  h16_cnt;
  logic [3:0][31:0] h16_res;
  logic [1:0]       w32_bit4;

  assign size_16 = (in_size == e16);
  assign size_32 = (in_size == e32);
  assign size_64 = (in_size == e64);

  // Four 16-bit partial shifts
  // Upper half of each result holds the bits pushed out of the chunk
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      h16_cnt[k] = ({4{size_64}} & cnt.c64[3:0])
                 | ({4{size_32}} & cnt.c32[k/2][3:0])
                 | ({4{size_16}} & cnt.c16[k]);
      h16_res[k] = {16'b0, src[16*k +: 16]} << h16_cnt[k];
    end
  end

  // 16-bit lanes keep only their own bits
  always_comb
  begin
    for (int k = 0; k < 4; k++)
      l16_out[16*k +: 16] = h16_res[k][15:0];
  end

  // Pairs of chunks form the 32-bit lanes
  always_comb
  begin
    for (int j = 0; j < 2; j++)
    begin
      w32_bit4[j] = (size_64 & cnt.c64[4]) | (size_32 & cnt.c32[j][4]);
      if (w32_bit4[j])
        l32_out[32*j +: 32] = {h16_res[2*j][15:0], 16'b0};
      else
        l32_out[32*j +: 32] = {h16_res[2*j+1][15:0] | h16_res[2*j][31:16],
                               h16_res[2*j][15:0]};
    end
  end

  // Whole-word lane, coarse step by 16-bit multiples
  always_comb
  begin
    case (cnt.c64[5:4])
      2'b00:
        l64_out = {h16_res[3][15:0] | h16_res[2][31:16],
                   h16_res[2][15:0] | h16_res[1][31:16],
                   h16_res[1][15:0] | h16_res[0][31:16],
                   h16_res[0][15:0]};
      2'b01:
        l64_out = {h16_res[2][15:0] | h16_res[1][31:16],
                   h16_res[1][15:0] | h16_res[0][31:16],
                   h16_res[0][15:0],
                   16'b0};
      2'b10:
        l64_out = {h16_res[1][15:0] | h16_res[0][31:16],
                   h16_res[0][15:0],
                   32'b0};
      default:
        l64_out = {h16_res[0][15:0], 48'b0};
    endcase
  end

endmodule

/* design/vshift_pkg.sv */
package vshift_pkg;

  // Beat geometry
  localparam int data_w     = 64;
  localparam int max_beats  = 4;
  localparam int beat_idx_w = $clog2(max_beats);

  // Element width, one-hot as on the shifter size input
  typedef enum logic [2:0] {
    e16 = 3'b001,
    e32 = 3'b010,
    e64 = 3'b100
  } elem_size_e;

  typedef enum logic [1:0] {
    op_sll = 2'd0,
    op_srl = 2'd1,
    op_sra = 2'd2
  } shift_op_e;

  // Command latched on cmd_start
  typedef struct packed {
    shift_op_e               op;
    elem_size_e              size;
    // Number of beats minus one
    logic [beat_idx_w-1:0]   last_beat_idx;
  } vshift_cmd_t;

  // One source beat, data plus per-element amounts
  typedef struct packed {
    logic [data_w-1:0] src;
    logic [data_w-1:0] amt;
  } vshift_beat_t;

  // Per-lane shift counts for each element size
  typedef struct packed {
    logic [3:0][3:0] c16;
    logic [1:0][4:0] c32;
    logic [5:0]      c64;
  } lane_cnt_t;

  // Registered result beat
  typedef struct packed {
    logic [data_w-1:0]     data;
    logic [beat_idx_w-1:0] idx;
  } vshift_res_t;

endpackage
